// File: all.f
hw/rvPkg.sv
hw/progLoader.sv
hw/wordRam.sv
hw/multiCycleCore.sv
hw/rvSystem.sv
verif/rvSystem_chk.sv
verif/rvScoreboard.sv
verif/tbRvSystem.sv

// File: Makefile
SRCS := $(filter-out +%,$(shell cat all.f))

.PHONY: run clean

run: obj_dir/VtbRvSystem
	@out="$$(./obj_dir/VtbRvSystem)"; echo "$$out"; echo "$$out" | grep -qx "No errors"

obj_dir/VtbRvSystem: all.f $(SRCS)
	verilator --binary --assert --top-module tbRvSystem -f all.f -Mdir obj_dir

clean:
	rm -rf obj_dir

// File: verif/tbRvSystem.sv
`timescale 1ns/1ps

module tbRvSystem import rvPkg::*; ();

	localparam int numTests    = 6;
	localparam int maxInstr    = 40;
	// run at 5 cycles worst case, load at up to 6 per word, readout, reset
	localparam int testCycles  = maxInstr * 5 + (maxInstr + 2) * 6 + dmemWords + 20;
	localparam int limitCycles = 2 * numTests * testCycles;

	logic        CLOCK_50;
	logic        rstn;
	logic        loadReq;
	logic [31:0] loadData;
	logic [5:0]  rdAddr;
	logic        loadAck;
	logic        done;
	logic [31:0] rdData;
	logic [31:0] cycleCount;
	logic [31:0] instrCount;
	logic        readPhase; // rdAddr sweep in progress
	logic [31:0] seed = 32'hcccc5b5f;
	logic [31:0] prog [$];
	int          testCount;
	int          checkCount;
	int          errCount;

	rvSystem i_dut (
		.CLOCK_50  (CLOCK_50),
		.rstn      (rstn),
		.loadReq   (loadReq),
		.loadData  (loadData),
		.rdAddr    (rdAddr),
		.loadAck   (loadAck),
		.done      (done),
		.rdData    (rdData),
		.cycleCount(cycleCount),
		.instrCount(instrCount)
	);

	rvScoreboard i_sb (
		.CLOCK_50  (CLOCK_50),
		.rstn      (rstn),
		.loadAck   (loadAck),
		.loadData  (loadData),
		.done      (done),
		.readPhase (readPhase),
		.rdAddr    (rdAddr),
		.rdData    (rdData),
		.cycleCount(cycleCount),
		.instrCount(instrCount),
		.testCount (testCount),
		.checkCount(checkCount),
		.errCount  (errCount)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #50 CLOCK_50 = ~CLOCK_50; // 100 ns period
	end

	// lcg step, upper half used since low bits cycle fast
	function automatic int unsigned pick(input int unsigned range);
		seed = seed * 32'd1664525 + 32'd1013904223;
		return 32'(seed[31:16]) % range;
	endfunction

	// one random instruction at index idx of n, branches only jump forward
	function automatic logic [31:0] randInstr(input int idx, input int n);
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] off12;
		logic [12:0] off13;
		logic [2:0]  f3;
		rd    = 5'(pick(8)); // x0..x7
		rs1   = 5'(pick(8));
		rs2   = 5'(pick(8));
		off12 = 12'(4 * pick(16)); // word 0..15 off x0
		off13 = 13'(4 * (1 + pick(n - idx))); // lands at most on the end marker
		f3    = (pick(2) == 0) ? f3Beq : f3Blt;
		case (pick(10))
			0: return {f7Base, rs2, rs1, f3Add, rd, opR};
			1: return {f7Sub, rs2, rs1, f3Add, rd, opR};
			2: return {f7Mul, rs2, rs1, f3Add, rd, opR};
			3: return {12'(pick(4096)), rs1, f3Add, rd, opImm};
			4: return {4'(pick(16)), 16'(pick(65536)), rd, opLui};
			5: return {4'(pick(16)), 16'(pick(65536)), rd, opAuipc};
			6: return {off12, 5'd0, f3Word, rd, opLoad};
			7: return {off12[11:5], rs2, 5'd0, f3Word, off12[4:0], opStore};
			default: return {off13[12], off13[10:5], rs2, rs1, f3, off13[4:1], off13[11], opBranch};
		endcase
	endfunction

	task automatic stepCycle();
		@(posedge CLOCK_50);
		#1; // inputs move just after the edge
	endtask

	task automatic applyReset();
		rstn = 1'b0;
		repeat (16) stepCycle();
		rstn = 1'b1;
	endtask

	task automatic makeProgram();
		int n;
		n = 8 + int'(pick(maxInstr - 7));
		prog.delete();
		for (int i = 0; i < n; i++)
			prog.push_back(randInstr(i, n));
		prog.push_back(eofWord);
	endtask

	// host side of the four-phase handshake
	task automatic sendWord(input logic [31:0] w);
		loadData = w;
		loadReq  = 1'b1;
		do stepCycle(); while (!loadAck);
		repeat (pick(3)) stepCycle(); // hold req a bit, back-pressure
		loadReq = 1'b0;
		do stepCycle(); while (loadAck);
	endtask

	task automatic readOut();
		readPhase = 1'b1;
		for (int a = 0; a < dmemWords; a++) begin
			rdAddr = 6'(a);
			stepCycle();
		end
		stepCycle(); // data of the last address
		readPhase = 1'b0;
		repeat (2) stepCycle(); // scoreboard closes the test
	endtask

	initial begin
		rstn      = 1'b0;
		loadReq   = 1'b0;
		loadData  = '0;
		rdAddr    = '0;
		readPhase = 1'b0;
		for (int t = 0; t < numTests; t++) begin
			applyReset();
			makeProgram();
			foreach (prog[i])
				sendWord(prog[i]);
			sendWord({16'(pick(65536)), 16'(pick(65536))}); // stray word, acked and dropped
			while (!done)
				stepCycle();
			readOut();
		end
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			testCount, checkCount, errCount, i_dut.u_chk.failCount);
		if (errCount == 0 && i_dut.u_chk.failCount == 0 && testCount == numTests)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// watchdog
	initial begin
		repeat (limitCycles) @(posedge CLOCK_50);
		$display("watchdog: run did not finish within %0d cycles", limitCycles);
		$display("Errors found");
		$finish;
	end

endmodule

// File: verif/rvScoreboard.sv
`timescale 1ns/1ps

module rvScoreboard import rvPkg::*; (
	input  logic        CLOCK_50,
	input  logic        rstn,
	input  logic        loadAck,
	input  logic [31:0] loadData,
	input  logic        done,
	input  logic        readPhase,
	input  logic [5:0]  rdAddr,
	input  logic [31:0] rdData,
	input  logic [31:0] cycleCount,
	input  logic [31:0] instrCount,
	output int          testCount,
	output int          checkCount,
	output int          errCount
);

	logic [31:0] memModel [dmemWords]; // ram is never cleared by reset, so neither is this
	logic [31:0] prog [$];
	logic        closed;   // end marker seen
	logic        ackPrev;
	logic        readPrev;
	logic        havePend; // an address is waiting for its data
	logic [5:0]  pendAddr;
	int          expInstr;
	int          expCycles;
	int          tests = 0;
	int          checks = 0;
	int          errs = 0;
	int          testErrs = 0;

	assign testCount  = tests;
	assign checkCount = checks;
	assign errCount   = errs;

	initial begin
		for (int i = 0; i < dmemWords; i++)
			memModel[i] = '0; // power-up contents
	end

	task automatic checkWord(input string what, input logic [31:0] expV, input logic [31:0] actV);
		checks++;
		if (actV !== expV) begin
			$display("ERROR test %0d %s: expected %h, actual %h", tests + 1, what, expV, actV);
			errs++;
			testErrs++;
		end
	endtask

	// ISA model, one instruction per loop pass, pc as a word index
	task automatic runModel();
		logic [31:0] regs [32];
		logic [31:0] raw;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] addr;
		instrWord_u  w;
		logic        wr;
		int          pc;
		int          next;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		pc        = 0;
		expInstr  = 0;
		expCycles = 2; // IF and ID of the end marker
		while (pc < prog.size() && prog[pc] != eofWord) begin
			raw  = prog[pc];
			w    = raw;
			a    = regs[w.rFields.rs1];
			b    = regs[w.rFields.rs2];
			res  = '0;
			wr   = 1'b1;
			next = pc + 1;
			expInstr++;
			case (w.rFields.opcode)
				opR: begin
					if (w.rFields.funct7 == f7Sub)
						res = a - b;
					else if (w.rFields.funct7 == f7Mul)
						res = a * b; // low word only
					else
						res = a + b;
					expCycles += 4;
				end
				opImm: begin
					res = a + {{20{raw[31]}}, raw[31:20]};
					expCycles += 4;
				end
				opLui: begin
					res = {raw[31:12], 12'b0};
					expCycles += 4;
				end
				opAuipc: begin
					res = 32'(pc * 4) + {raw[31:12], 12'b0};
					expCycles += 5;
				end
				opLoad: begin
					addr = a + {{20{raw[31]}}, raw[31:20]};
					res  = memModel[addr[7:2]];
					expCycles += 5;
				end
				opStore: begin
					addr = a + {{20{raw[31]}}, raw[31:25], raw[11:7]};
					memModel[addr[7:2]] = b;
					wr = 1'b0;
					expCycles += 4;
				end
				default: begin // beq / blt, B-type offset in bytes
					res = {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
					if (w.rFields.funct3 == f3Blt ? $signed(a) < $signed(b) : a == b)
						next = pc + int'($signed(res)) / 4;
					wr = 1'b0;
					expCycles += 3;
				end
			endcase
			if (wr && w.rFields.rd != 5'd0)
				regs[w.rFields.rd] = res; // x0 never written
			pc = next;
		end
	endtask

	task automatic finishTest();
		checkWord("instrCount", 32'(expInstr), instrCount);
		checkWord("cycleCount", 32'(expCycles), cycleCount);
		tests++;
		$display("test %0d %s: %0d instructions, %0d cycles, %0d mismatches", tests,
			testErrs == 0 ? "passed" : "failed", expInstr, expCycles, testErrs);
		testErrs = 0;
		havePend = 1'b0;
	endtask

	// everything sampled mid-cycle, away from the driving edge
	always @(negedge CLOCK_50) begin
		if (!rstn) begin
			prog.delete();
			closed   = 1'b0;
			ackPrev  = 1'b0;
			readPrev = 1'b0;
			havePend = 1'b0;
		end else begin
			if (loadAck && !ackPrev && !closed) begin // one word per ack
				prog.push_back(loadData);
				if (loadData == eofWord) begin
					closed = 1'b1; // later words are dropped by the loader too
					runModel();
				end
			end
			ackPrev = loadAck;
			if (readPhase) begin
				if (!done) begin
					$display("ERROR test %0d: done was low during readout", tests + 1);
					errs++;
					testErrs++;
				end
				if (havePend) // data for last cycle's address
					checkWord($sformatf("dmem[%0d]", pendAddr), memModel[pendAddr], rdData);
				pendAddr = rdAddr;
				havePend = 1'b1;
			end else if (readPrev) begin
				finishTest();
			end
			readPrev = readPhase;
		end
	end

endmodule

// File: verif/rvSystem_chk.sv
`timescale 1ns/1ps

module rvSystem_chk import rvPkg::*; (
	input logic        CLOCK_50,
	input logic        rstn,
	input logic        loadReq,
	input logic        loadAck,
	input logic        progReady,
	input logic        dmemWe,
	input logic        done,
	input logic [2:0]  state,
	input logic [31:0] cycleCount,
	input logic [31:0] instrCount
);

	int failCount = 0; // summed up by the testbench at the end

	// four-phase: ack only answers a request, and only lets go once req is gone
	ackNeedsReq: assert property (@(posedge CLOCK_50) disable iff (!rstn)
		$rose(loadAck) |-> $past(loadReq))
		else begin
			$error("loadAck rose with no loadReq pending");
			failCount++;
		end

	ackFallsAfterReq: assert property (@(posedge CLOCK_50) disable iff (!rstn)
		$fell(loadAck) |-> !$past(loadReq))
		else begin
			$error("loadAck fell while loadReq was still high");
			failCount++;
		end

	storeOnlyInMem: assert property (@(posedge CLOCK_50) disable iff (!rstn)
		dmemWe |-> state == stMem)
		else begin
			$error("dmemWe high outside the MEM stage");
			failCount++;
		end

	// core must not start before the whole program is in
	holdInit: assert property (@(posedge CLOCK_50) disable iff (!rstn)
		(state == stInit && !progReady) |=> state == stInit)
		else begin
			$error("core left init before progReady");
			failCount++;
		end

	doneSticky: assert property (@(posedge CLOCK_50) disable iff (!rstn)
		done |=> done)
		else begin
			$error("done dropped without a reset");
			failCount++;
		end

	resetClears: assert property (@(posedge CLOCK_50)
		!rstn |=> (!done && !loadAck && cycleCount == '0 && instrCount == '0))
		else begin
			$error("reset left done, loadAck or a counter set");
			failCount++;
		end

endmodule

bind rvSystem rvSystem_chk u_chk (
	.CLOCK_50  (CLOCK_50),
	.rstn      (rstn),
	.loadReq   (loadReq),
	.loadAck   (loadAck),
	.progReady (progReady),
	.dmemWe    (dmemWe),
	.done      (done),
	.state     (i_core.state),
	.cycleCount(cycleCount),
	.instrCount(instrCount)
);

// File: hw/rvSystem.sv
`timescale 1ns/1ps

module rvSystem import rvPkg::*; (
	input  logic        CLOCK_50,
	input  logic        rstn,
	input  logic        loadReq,
	input  logic [31:0] loadData,
	input  logic [5:0]  rdAddr,
	output logic        loadAck,
	output logic        done,
	output logic [31:0] rdData,
	output logic [31:0] cycleCount,
	output logic [31:0] instrCount
);

	logic        progReady;
	logic        imemWe;
	logic [5:0]  imemAddr;
	logic [31:0] imemData;
	logic [5:0]  fetchAddr;
	logic [31:0] instr;
	logic [5:0]  dmemAddr;
	logic        dmemWe;
	logic [31:0] dmemWdata;
	logic [31:0] dmemRdata;

	progLoader i_loader (
		.CLOCK_50 (CLOCK_50),
		.rstn     (rstn),
		.loadReq  (loadReq),
		.loadData (loadData),
		.loadAck  (loadAck),
		.progReady(progReady),
		.imemWe   (imemWe),
		.imemAddr (imemAddr),
		.imemData (imemData)
	);

	// port A written by the loader, port B fetched by the core
	wordRam #(.depthWords(imemWords)) i_imem (
		.CLOCK_50(CLOCK_50),
		.weA     (imemWe),
		.addrA   (imemAddr),
		.wdataA  (imemData),
		.addrB   (fetchAddr),
		.rdataA  (),
		.rdataB  (instr)
	);

	// port A for the core, port B is the host readout
	wordRam #(.depthWords(dmemWords)) i_dmem (
		.CLOCK_50(CLOCK_50),
		.weA     (dmemWe),
		.addrA   (dmemAddr),
		.wdataA  (dmemWdata),
		.addrB   (rdAddr),
		.rdataA  (dmemRdata),
		.rdataB  (rdData)
	);

	multiCycleCore i_core (
		.CLOCK_50  (CLOCK_50),
		.rstn      (rstn),
		.progReady (progReady),
		.instr     (instr),
		.dmemRdata (dmemRdata),
		.fetchAddr (fetchAddr),
		.dmemAddr  (dmemAddr),
		.dmemWe    (dmemWe),
		.dmemWdata (dmemWdata),
		.done      (done),
		.cycleCount(cycleCount),
		.instrCount(instrCount)
	);

endmodule

// File: hw/multiCycleCore.sv
`timescale 1ns/1ps

module multiCycleCore import rvPkg::*; (
	input  logic        CLOCK_50,
	input  logic        rstn,
	input  logic        progReady,
	input  logic [31:0] instr,
	input  logic [31:0] dmemRdata,
	output logic [5:0]  fetchAddr,
	output logic [5:0]  dmemAddr,
	output logic        dmemWe,
	output logic [31:0] dmemWdata,
	output logic        done,
	output logic [31:0] cycleCount,
	output logic [31:0] instrCount
);

	logic [2:0]  state;
	logic [31:0] pc;
	logic [31:0] regs [32];
	logic [31:0] rs1Q, rs2Q;  // operand latches from ID
	logic [31:0] aluOut;
	logic [31:0] mdr;

	instrWord_u  ir;
	logic [6:0]  opcode;
	logic [4:0]  rd;
	logic [31:0] immI, immS, immB, immU;
	logic [31:0] aluRes;
	logic        known;  // opcode/funct combination we implement
	logic        taken;

	// pc is held for the whole instruction, so the imem output stays valid ID..WB
	assign ir        = instr;
	assign fetchAddr = pc[7:2];
	assign opcode    = ir.rFields.opcode;
	assign rd        = ir.rFields.rd;

	// immediates, all sign extended
	assign immI = {{20{ir.iFields.imm[11]}}, ir.iFields.imm};
	assign immS = {{20{ir.sFields.immHi[6]}}, ir.sFields.immHi, ir.sFields.immLo};
	assign immB = {{20{ir.sFields.immHi[6]}}, ir.sFields.immLo[0],
		ir.sFields.immHi[5:0], ir.sFields.immLo[4:1], 1'b0};
	assign immU = {ir.uFields.imm, 12'b0};

	// ALU, only meaningful once rs1Q/rs2Q are loaded
	always_comb begin
		aluRes = '0;
		known  = 1'b1;
		case (opcode)
			opR: begin
				if (ir.rFields.funct3 != f3Add)
					known = 1'b0;
				case (ir.rFields.funct7)
					f7Base:  aluRes = rs1Q + rs2Q;
					f7Sub:   aluRes = rs1Q - rs2Q;
					f7Mul:   aluRes = rs1Q * rs2Q; // low 32 bits
					default: known = 1'b0;
				endcase
			end
			opImm: begin
				aluRes = rs1Q + immI;
				known  = (ir.iFields.funct3 == f3Add);
			end
			opLoad: begin
				aluRes = rs1Q + immI; // byte address
				known  = (ir.iFields.funct3 == f3Word);
			end
			opStore: begin
				aluRes = rs1Q + immS;
				known  = (ir.sFields.funct3 == f3Word);
			end
			opLui:   aluRes = immU;
			opAuipc: aluRes = pc + immU; // pc of this instruction
			opBranch: known = (ir.sFields.funct3 == f3Beq) || (ir.sFields.funct3 == f3Blt);
			default: known = 1'b0;
		endcase
	end

	// branch decision
	always_comb begin
		if (ir.sFields.funct3 == f3Blt)
			taken = $signed(rs1Q) < $signed(rs2Q);
		else
			taken = (rs1Q == rs2Q);
	end

	// address goes out during EX so load data is back in MEM
	assign dmemAddr  = aluRes[7:2];
	assign dmemWdata = rs2Q;

	always_ff @(posedge CLOCK_50) begin
		if (!rstn) begin
			state      <= stInit;
			pc         <= '0;
			done       <= 1'b0;
			dmemWe     <= 1'b0;
			cycleCount <= '0;
			instrCount <= '0;
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else begin
			dmemWe <= 1'b0; // single cycle strobe, set from EX
			if (state != stInit && !done)
				cycleCount <= cycleCount + 32'd1;

			case (state)
				stInit: begin
					if (progReady) begin
						pc    <= '0;
						state <= stIf;
					end
				end
				stIf: state <= stId; // imem read in flight
				stId: begin
					if (instr == eofWord) begin
						done <= 1'b1; // park here
					end else begin
						rs1Q   <= regs[ir.rFields.rs1];
						rs2Q   <= regs[ir.rFields.rs2];
						aluOut <= pc + immB; // branch target, maybe unused
						state  <= stEx;
					end
				end
				stEx: begin
					instrCount <= instrCount + 32'd1;
					if (!known) begin
						pc    <= pc + 32'd4; // skip what we don't decode
						state <= stIf;
					end else if (opcode == opBranch) begin
						pc    <= taken ? aluOut : pc + 32'd4;
						state <= stIf;
					end else begin
						aluOut <= aluRes;
						dmemWe <= (opcode == opStore); // high during MEM only
						state  <= stMem;
					end
				end
				stMem: begin
					case (opcode)
						opLoad: begin
							mdr   <= dmemRdata;
							state <= stWb;
						end
						opAuipc: begin
							mdr   <= aluOut;
							state <= stWb;
						end
						opStore: begin
							pc    <= pc + 32'd4; // ram takes the write this edge
							state <= stIf;
						end
						default: begin // R-type, addi, lui
							if (rd != 5'd0)
								regs[rd] <= aluOut;
							pc    <= pc + 32'd4;
							state <= stIf;
						end
					endcase
				end
				stWb: begin
					if (rd != 5'd0)
						regs[rd] <= mdr; // x0 stays zero
					pc    <= pc + 32'd4;
					state <= stIf;
				end
				default: state <= stInit;
			endcase
		end
	end

endmodule

// File: hw/wordRam.sv
`timescale 1ns/1ps

module wordRam #(
	parameter int depthWords = 64
) (
	input  logic                          CLOCK_50,
	input  logic                          weA,
	input  logic [$clog2(depthWords)-1:0] addrA,
	input  logic [31:0]                   wdataA,
	input  logic [$clog2(depthWords)-1:0] addrB,
	output logic [31:0]                   rdataA,
	output logic [31:0]                   rdataB
);

	logic [31:0] mem [depthWords];

	// power-up contents, zeroed
	initial begin
		for (int i = 0; i < depthWords; i++)
			mem[i] = '0;
	end

	always_ff @(posedge CLOCK_50) begin
		if (weA)
			mem[addrA] <= wdataA;
		rdataA <= mem[addrA]; // old data on a write cycle
		rdataB <= mem[addrB]; // read-only port
	end

endmodule

// File: hw/progLoader.sv
`timescale 1ns/1ps

module progLoader import rvPkg::*; (
	input  logic        CLOCK_50,
	input  logic        rstn,
	input  logic        loadReq,
	input  logic [31:0] loadData,
	output logic        loadAck,
	output logic        progReady,
	output logic        imemWe,
	output logic [5:0]  imemAddr,
	output logic [31:0] imemData
);

	logic newWord; // req seen, not yet acked

	assign newWord = loadReq && !loadAck;

	// write straight from the host bus on the accepting edge
	assign imemWe   = newWord && !progReady; // late words are dropped
	assign imemData = loadData;

	// four-phase slave
	always_ff @(posedge CLOCK_50) begin
		if (!rstn) begin
			loadAck   <= 1'b0;
			progReady <= 1'b0;
			imemAddr  <= '0;
		end else begin
			if (newWord) begin
				loadAck <= 1'b1; // ack one cycle after the write
				if (!progReady) begin
					imemAddr <= imemAddr + 6'd1; // next free slot
					if (loadData == eofWord)
						progReady <= 1'b1; // program closed, held until reset
				end
			end else if (!loadReq && loadAck) begin
				loadAck <= 1'b0; // host let go of req
			end
			// req still high with ack high: host is holding us, just wait
		end
	end

endmodule

// File: hw/rvPkg.sv
package rvPkg;

	// major opcodes, low 7 bits of the word
	localparam logic [6:0] opR      = 7'b011_0011; // add, sub, mul
	localparam logic [6:0] opImm    = 7'b001_0011; // addi
	localparam logic [6:0] opLoad   = 7'b000_0011; // lw
	localparam logic [6:0] opStore  = 7'b010_0011; // sw
	localparam logic [6:0] opBranch = 7'b110_0011; // beq, blt
	localparam logic [6:0] opLui    = 7'b011_0111;
	localparam logic [6:0] opAuipc  = 7'b001_0111;

	// funct7 selects within R-type
	localparam logic [6:0] f7Base = 7'b000_0000;
	localparam logic [6:0] f7Sub  = 7'b010_0000;
	localparam logic [6:0] f7Mul  = 7'b000_0001; // M extension

	localparam logic [2:0] f3Add  = 3'b000;
	localparam logic [2:0] f3Word = 3'b010; // lw / sw width
	localparam logic [2:0] f3Beq  = 3'b000;
	localparam logic [2:0] f3Blt  = 3'b100;

	localparam logic [31:0] eofWord = 32'hFFFF_FFFF; // end of program marker

	localparam int imemWords = 64;
	localparam int dmemWords = 64;

	// core stages
	localparam logic [2:0] stInit = 3'd0;
	localparam logic [2:0] stIf   = 3'd1;
	localparam logic [2:0] stId   = 3'd2;
	localparam logic [2:0] stEx   = 3'd3;
	localparam logic [2:0] stMem  = 3'd4;
	localparam logic [2:0] stWb   = 3'd5;

	// one instruction word, seen through each encoding format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} rFields;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} iFields;
		struct packed {
			logic [6:0] immHi; // also B-type imm[12|10:5]
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] immLo; // also B-type imm[4:1|11]
			logic [6:0] opcode;
		} sFields;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} uFields;
	} instrWord_u;

endpackage
